//--- alu.sv
// integer alu plus branch condition for beq and bne
// slt is signed, bcond comes from the subtractor
`timescale 1ns/1ps

module alu (
  input  isa_pkg::alu_op_e op,
  input  logic [31:0]      a,
  input  logic [31:0]      b,
  input  logic [2:0]       funct3,
  output logic [31:0]      result,
  output logic             bcond
);

  logic [31:0] diff;
  logic        zero;

  assign diff = a - b;
  assign zero = (diff == 32'd0);

  always_comb begin
    case (op)
      isa_pkg::alu_add:    result = a + b;
      isa_pkg::alu_sub:    result = diff;
      isa_pkg::alu_and:    result = a & b;
      isa_pkg::alu_or:     result = a | b;
      isa_pkg::alu_xor:    result = a ^ b;
      isa_pkg::alu_slt:    result = {31'd0, $signed(a) < $signed(b)};
      isa_pkg::alu_pass_b: result = b;   // lui
      default:             result = '0;
    endcase
  end

  // only meaningful when execute holds a branch
  always_comb begin
    case (funct3)
      isa_pkg::f3_beq: bcond = zero;
      isa_pkg::f3_bne: bcond = !zero;
      default:         bcond = 1'b0;
    endcase
  end

endmodule

//--- decode_unit.sv
// control and immediate from one instruction word
// unsupported encodings give ctrl == 0, i.e. a no-op
// on ecall rs1 is forced to x17 so execute can check the exit code
`timescale 1ns/1ps

module decode_unit (
  input  isa_pkg::inst_u  inst,
  output pipe_pkg::ctrl_t ctrl,
  output logic [31:0]     imm,
  output logic [4:0]      rs1
);

  always_comb begin
    isa_pkg::alu_op_e r_op;
    logic r_ok;
    r_op = isa_pkg::alu_add;
    r_ok = (inst.r.funct7 == isa_pkg::f7_base);
    // r-type function select
    case (inst.r.funct3)
      isa_pkg::f3_add_sub: begin
        r_op = (inst.r.funct7 == isa_pkg::f7_sub) ? isa_pkg::alu_sub : isa_pkg::alu_add;
        r_ok = (inst.r.funct7 == isa_pkg::f7_base) || (inst.r.funct7 == isa_pkg::f7_sub);
      end
      isa_pkg::f3_slt: r_op = isa_pkg::alu_slt;
      isa_pkg::f3_xor: r_op = isa_pkg::alu_xor;
      isa_pkg::f3_or:  r_op = isa_pkg::alu_or;
      isa_pkg::f3_and: r_op = isa_pkg::alu_and;
      default:         r_ok = 1'b0;   // shifts, sltu
    endcase

    ctrl = '0;
    case (inst.r.opcode)
      isa_pkg::op_rtype: if (r_ok) begin
        ctrl.alu_op    = r_op;
        ctrl.reg_write = 1'b1;
      end
      isa_pkg::op_itype: if (inst.i.funct3 == isa_pkg::f3_add_sub) begin // addi only
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      isa_pkg::op_load: if (inst.i.funct3 == isa_pkg::f3_lw) begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      isa_pkg::op_store: if (inst.s.funct3 == isa_pkg::f3_sw) begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      isa_pkg::op_branch:
        if (inst.b.funct3 == isa_pkg::f3_beq || inst.b.funct3 == isa_pkg::f3_bne) begin
          ctrl.alu_op    = isa_pkg::alu_sub;  // compare by subtraction
          ctrl.is_branch = 1'b1;
        end
      isa_pkg::op_jal: begin
        ctrl.is_jal    = 1'b1;
        ctrl.pc_to_reg = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      isa_pkg::op_jalr: begin
        ctrl.alu_src_imm = 1'b1;   // alu forms rs1 + imm
        ctrl.is_jalr     = 1'b1;
        ctrl.pc_to_reg   = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      isa_pkg::op_lui: begin
        ctrl.alu_op      = isa_pkg::alu_pass_b;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      isa_pkg::op_system:   // plain ecall, ebreak and csr ops ignored
        ctrl.is_ecall = (inst.i.imm == 12'd0) && (inst.i.funct3 == 3'd0);
      default: ctrl = '0;
    endcase
  end

  // immediate through the format view its opcode selects
  always_comb begin
    case (inst.r.opcode)
      isa_pkg::op_itype, isa_pkg::op_load, isa_pkg::op_jalr:
        imm = {{20{inst.i.imm[11]}}, inst.i.imm};
      isa_pkg::op_store:
        imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      isa_pkg::op_branch:
        imm = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
      isa_pkg::op_lui:
        imm = {inst.u.imm, 12'd0};
      isa_pkg::op_jal:
        imm = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};
      default: imm = '0;
    endcase
  end

  assign rs1 = ctrl.is_ecall ? isa_pkg::halt_reg : inst.r.rs1;

endmodule

//--- filelist.f
isa_pkg.sv
pipe_pkg.sv
sram.sv
reg_file.sv
decode_unit.sv
alu.sv
hazard_unit.sv
rv_core.sv
rv_core_properties.sv
tb_rv_core.sv

//--- hazard_unit.sv
// forwarding selects for execute, load-use stall, flush on redirect
// mem stage wins over wb, x0 is never forwarded
`timescale 1ns/1ps

module hazard_unit (
  input  logic [4:0]          id_rs1,
  input  logic [4:0]          id_rs2,
  input  logic [4:0]          ex_rs1,
  input  logic [4:0]          ex_rs2,
  input  logic [4:0]          ex_rd,
  input  logic [4:0]          mem_rd,
  input  logic [4:0]          wb_rd,
  input  logic                ex_mem_read,
  input  logic                mem_reg_write,
  input  logic                wb_reg_write,
  input  logic                redirect,
  output pipe_pkg::fwd_sel_e  fwd_a,
  output pipe_pkg::fwd_sel_e  fwd_b,
  output logic                stall,
  output logic                flush
);

  function automatic pipe_pkg::fwd_sel_e pick(input logic [4:0] src);
    pipe_pkg::fwd_sel_e sel;
    sel = pipe_pkg::fwd_none;
    if (src != 5'd0) begin
      if (mem_reg_write && mem_rd == src) begin
        sel = pipe_pkg::fwd_mem;   // youngest value
      end else if (wb_reg_write && wb_rd == src) begin
        sel = pipe_pkg::fwd_wb;
      end
    end
    return sel;
  endfunction

  assign fwd_a = pick(ex_rs1);
  assign fwd_b = pick(ex_rs2);

  // load data only exists in mem, one bubble needed
  // rs2 of an i-type may match spuriously, costs a cycle only
  assign stall = ex_mem_read && (ex_rd != 5'd0) &&
                 (ex_rd == id_rs1 || ex_rd == id_rs2);

  assign flush = redirect;   // taken transfer or halting ecall

endmodule

//--- isa_pkg.sv
// RV32I encodings for the supported subset only
// shifts, sltu, byte and halfword forms are not listed and decode as no-ops
package isa_pkg;

  // major opcodes
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_add_sub = 3'b000; // add, sub, addi
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_lw      = 3'b010;
  localparam logic [2:0] f3_sw      = 3'b010;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [6:0] f7_base    = 7'b0000000;
  localparam logic [6:0] f7_sub     = 7'b0100000;

  // ecall convention, a7 == 10 means exit
  localparam logic [31:0] halt_code = 32'd10;
  localparam logic [4:0]  halt_reg  = 5'd17;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;   // imm[11:5]
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;   // imm[4:0]
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;     // upper 20 bits
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one word, six views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage

//--- pipe_pkg.sv
// pipeline register layouts and memory depths
// an all-zero ctrl is a bubble, so '0 clears any stage
package pipe_pkg;

  localparam int imem_words = 256;
  localparam int dmem_words = 256;

  typedef struct packed {
    isa_pkg::alu_op_e alu_op;
    logic alu_src_imm;   // b operand from imm
    logic mem_read;
    logic mem_write;
    logic reg_write;
    logic mem_to_reg;    // wb takes load data
    logic pc_to_reg;     // link value pc+4
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic is_ecall;
  } ctrl_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic [4:0]  rs1, rs2, rd;
    logic [2:0]  funct3;
  } id_ex_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] alu_out;    // pc+4 for jal and jalr
    logic [31:0] store_data;
    logic [4:0]  rd;
    logic        halt;
  } ex_mem_t;

  typedef struct packed {
    logic        reg_write;
    logic        mem_to_reg;
    logic [31:0] alu_out;
    logic [31:0] load_data;
    logic [4:0]  rd;
    logic        halt;
  } mem_wb_t;

  typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_e;

endpackage

//--- reg_file.sv
// 32 x 32 integer register file, x0 reads as zero
// a write in the same cycle as a read of that register is returned directly
`timescale 1ns/1ps

module reg_file (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < 32; k++) regs[k] <= '0;
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // write-through so wb and decode can share a cycle
  assign rs1_data = (rs1 == 5'd0) ? '0 :
                    (we && rd == rs1) ? wdata : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 :
                    (we && rd == rs2) ? wdata : regs[rs2];

endmodule

//--- run.sh
#!/bin/sh
# build and run the rv_core testbench with verilator
# exit status is nonzero when the simulation stops with $fatal or an assertion error
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f filelist.f
./obj_dir/Vtb_rv_core

//--- rv_core.sv
// five-stage rv32i core, branches resolved in execute, predicted not taken
// boot port writes imem only while reset is high, boot_addr is a word index
// retire reports each nonzero-rd writeback one edge after mem/wb
// after a halting ecall reaches wb everything freezes until reset
`timescale 1ns/1ps

module rv_core (
  input  logic        clk,
  input  logic        reset,
  input  logic        boot_we,
  input  logic [31:0] boot_addr,
  input  logic [31:0] boot_data,
  output logic        retire_valid,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_data,
  output logic        is_halted
);

  logic [31:0]        pc, pc_next, imem_rdata, imem_addr, if_id_pc;
  logic               imem_we, run, stall, flush;
  isa_pkg::inst_u     if_id_inst;
  pipe_pkg::ctrl_t    dec_ctrl;
  logic [31:0]        dec_imm, rf_rs1_data, rf_rs2_data;
  logic [4:0]         dec_rs1;
  pipe_pkg::id_ex_t   id_ex, id_ex_d;
  pipe_pkg::ex_mem_t  ex_mem, ex_mem_d;
  pipe_pkg::mem_wb_t  mem_wb, mem_wb_d;
  pipe_pkg::fwd_sel_e fwd_a, fwd_b;
  logic [31:0]        fwd_a_val, fwd_b_val, alu_b, alu_result, ex_pc_plus4;
  logic [31:0]        redirect_pc, dmem_rdata, wb_data;
  logic               bcond, taken, halt_ex, redirect;

  assign run = !is_halted;   // freeze once halted

  // fetch
  assign imem_we   = reset && boot_we;
  assign imem_addr = imem_we ? boot_addr : {2'b00, pc[31:2]};

  sram #(.words(pipe_pkg::imem_words)) imem (
    .clk(clk), .we(imem_we), .addr(imem_addr), .wdata(boot_data), .rdata(imem_rdata)
  );

  assign pc_next = redirect ? redirect_pc : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (run && (redirect || !stall)) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      if_id_inst <= '0;   // zero word decodes as bubble
      if_id_pc   <= '0;
    end else if (run) begin
      if (flush) begin
        if_id_inst <= '0;
        if_id_pc   <= '0;
      end else if (!stall) begin
        if_id_inst <= imem_rdata;
        if_id_pc   <= pc;
      end
    end
  end

  // decode
  decode_unit dec (.inst(if_id_inst), .ctrl(dec_ctrl), .imm(dec_imm), .rs1(dec_rs1));

  reg_file rf (
    .clk(clk), .reset(reset),
    .rs1(dec_rs1), .rs2(if_id_inst.r.rs2),
    .rd(mem_wb.rd), .we(mem_wb.reg_write && run), .wdata(wb_data),
    .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data)
  );

  always_comb begin
    id_ex_d.ctrl     = dec_ctrl;
    id_ex_d.pc       = if_id_pc;
    id_ex_d.rs1_data = rf_rs1_data;
    id_ex_d.rs2_data = rf_rs2_data;
    id_ex_d.imm      = dec_imm;
    id_ex_d.rs1      = dec_rs1;
    id_ex_d.rs2      = if_id_inst.r.rs2;
    id_ex_d.rd       = if_id_inst.r.rd;
    id_ex_d.funct3   = if_id_inst.r.funct3;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex <= '0;
    end else if (run) begin
      id_ex <= (flush || stall) ? '0 : id_ex_d;  // bubble on squash or load-use
    end
  end

  // execute
  hazard_unit hz (
    .id_rs1(dec_rs1), .id_rs2(if_id_inst.r.rs2),
    .ex_rs1(id_ex.rs1), .ex_rs2(id_ex.rs2), .ex_rd(id_ex.rd),
    .mem_rd(ex_mem.rd), .wb_rd(mem_wb.rd),
    .ex_mem_read(id_ex.ctrl.mem_read),
    .mem_reg_write(ex_mem.ctrl.reg_write), .wb_reg_write(mem_wb.reg_write),
    .redirect(redirect),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .flush(flush)
  );

  function automatic logic [31:0] fwd_value(input pipe_pkg::fwd_sel_e sel,
                                            input logic [31:0] reg_val);
    case (sel)
      pipe_pkg::fwd_mem: return ex_mem.alu_out;
      pipe_pkg::fwd_wb:  return wb_data;
      default:           return reg_val;
    endcase
  endfunction

  assign fwd_a_val = fwd_value(fwd_a, id_ex.rs1_data);
  assign fwd_b_val = fwd_value(fwd_b, id_ex.rs2_data);
  assign alu_b     = id_ex.ctrl.alu_src_imm ? id_ex.imm : fwd_b_val;

  alu ex_alu (
    .op(id_ex.ctrl.alu_op), .a(fwd_a_val), .b(alu_b), .funct3(id_ex.funct3),
    .result(alu_result), .bcond(bcond)
  );

  assign ex_pc_plus4 = id_ex.pc + 32'd4;
  assign halt_ex     = id_ex.ctrl.is_ecall && (fwd_a_val == isa_pkg::halt_code); // a7 fwd
  assign taken       = id_ex.ctrl.is_jal || (id_ex.ctrl.is_branch && bcond);
  assign redirect    = taken || id_ex.ctrl.is_jalr || halt_ex;

  always_comb begin
    if (id_ex.ctrl.is_jalr) begin
      redirect_pc = {alu_result[31:1], 1'b0};
    end else if (taken) begin
      redirect_pc = id_ex.pc + id_ex.imm;
    end else begin
      redirect_pc = ex_pc_plus4;   // halt, fetch path is dead anyway
    end
  end

  always_comb begin
    ex_mem_d.ctrl       = id_ex.ctrl;
    ex_mem_d.alu_out    = id_ex.ctrl.pc_to_reg ? ex_pc_plus4 : alu_result;
    ex_mem_d.store_data = fwd_b_val;
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.halt       = halt_ex;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem <= '0;
    end else if (run) begin
      ex_mem <= ex_mem_d;
    end
  end

  // memory, word accesses only
  sram #(.words(pipe_pkg::dmem_words)) dmem (
    .clk(clk), .we(ex_mem.ctrl.mem_write && run),
    .addr({2'b00, ex_mem.alu_out[31:2]}), .wdata(ex_mem.store_data),
    .rdata(dmem_rdata)
  );

  always_comb begin
    mem_wb_d.reg_write  = ex_mem.ctrl.reg_write;
    mem_wb_d.mem_to_reg = ex_mem.ctrl.mem_to_reg;
    mem_wb_d.alu_out    = ex_mem.alu_out;
    mem_wb_d.load_data  = dmem_rdata;
    mem_wb_d.rd         = ex_mem.rd;
    mem_wb_d.halt       = ex_mem.halt;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb <= '0;
    end else if (run) begin
      mem_wb <= mem_wb_d;
    end
  end

  // writeback and retire report
  assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_out;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
      retire_rd    <= '0;
      retire_data  <= '0;
      is_halted    <= 1'b0;
    end else begin
      retire_valid <= run && mem_wb.reg_write && (mem_wb.rd != 5'd0);
      retire_rd    <= mem_wb.rd;
      retire_data  <= wb_data;
      is_halted    <= is_halted || mem_wb.halt;   // sticky until reset
    end
  end

endmodule

//--- rv_core_properties.sv
// concurrent checks on the retire and halt ports of rv_core
// attached with bind, sees only port-level signals
// halt checks assume no reset pulse in the middle of a run
`timescale 1ns/1ps

module rv_core_properties (
  input logic       clk,
  input logic       reset,
  input logic       retire_valid,
  input logic [4:0] retire_rd,
  input logic       is_halted
);

  // x0 writes are filtered before the retire port
  a_retire_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> retire_rd != 5'd0)
    else $error("retire_valid high with retire_rd equal to x0");

  // halt is sticky until reset
  a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> is_halted)
    else $error("is_halted fell without reset");

  // frozen core, nothing commits
  a_no_retire_halted: assert property (@(posedge clk) disable iff (reset)
    is_halted |-> !retire_valid)
    else $error("retire_valid high while halted");

  a_reset_clears: assert property (@(posedge clk)
    reset |=> !retire_valid && !is_halted)
    else $error("retire_valid or is_halted high right after reset");

endmodule

//--- sram.sv
// word-addressed memory, combinational read, write on the clock edge
// upper address bits beyond the depth are ignored, so addresses wrap
// no reset, contents are undefined until written
`timescale 1ns/1ps

module sram #(
  parameter int words = 256
) (
  input  logic        clk,
  input  logic        we,
  input  logic [31:0] addr,   // word index, not byte address
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  logic [31:0] mem [words];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr[$clog2(words)-1:0]] <= wdata;
    end
  end

  assign rdata = mem[addr[$clog2(words)-1:0]]; // async read

endmodule

//--- tb_rv_core.sv
// boots a fixed program into rv_core and checks the retire stream
// expected writebacks are worked out by hand in program order, wrong-path skipped
// reset stays high for the whole boot load, then 3 more cycles
// imem words past the program are random and must never retire
`timescale 1ns/1ps

module tb_rv_core;

  localparam int prog_len   = 37;
  localparam int n_exp      = 21;
  localparam int max_cycles = 10 * (prog_len + 3);  // ~10 cycles per instruction
  localparam int drain      = 4;                    // cycles watched after halt

  localparam logic [6:0] op_imm  = 7'b0010011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_jalr = 7'b1100111;

  // expected retire rows as rd and value
  localparam logic [31:0] exp_rd [n_exp] = '{
    32'd1, 32'd2, 32'd3, 32'd4, 32'd5, 32'd6, 32'd7, 32'd8, 32'd9,  // alu chain
    32'd10, 32'd10, 32'd11, 32'd12,                                  // lui, lw, use
    32'd15, 32'd16, 32'd18, 32'd19,                                  // branches, jumps
    32'd21, 32'd17, 32'd22, 32'd17                                   // x0, ecalls
  };
  localparam logic [31:0] exp_data [n_exp] = '{
    32'h0000_0005, 32'hffff_fffd, 32'h0000_0002, 32'hffff_fffd, 32'h0000_0005,
    32'h0000_0007, 32'hffff_fffa, 32'h0000_0001, 32'h0000_0000,
    32'h1234_5000, 32'h1234_5678, 32'h1234_5678, 32'h1234_567d,
    32'h0000_0001, 32'h0000_0058, 32'h0000_006d, 32'h0000_0068,
    32'h0000_0001, 32'h0000_0003, 32'h0000_0084, 32'h0000_000a
  };

  logic        clk, reset, boot_we;
  logic [31:0] boot_addr, boot_data;
  logic        retire_valid, is_halted;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic [31:0] prog [prog_len];
  int          cycles, seen, halt_cycles;

  rv_core rv_core_inst (
    .clk(clk), .reset(reset),
    .boot_we(boot_we), .boot_addr(boot_addr), .boot_data(boot_data),
    .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data),
    .is_halted(is_halted)
  );

  bind rv_core rv_core_properties props_inst (
    .clk(clk), .reset(reset), .retire_valid(retire_valid),
    .retire_rd(retire_rd), .is_halted(is_halted)
  );

  always #2 clk = ~clk;  // 4 ns period

  // rv32i encoders by instruction format
  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw only
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};  // lui
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic build_program();
    prog[0]  = i_word(12'd5, 5'd0, 3'b000, 5'd1, op_imm);     // addi x1, x0, 5
    prog[1]  = i_word(12'hffd, 5'd0, 3'b000, 5'd2, op_imm);   // addi x2, x0, -3
    prog[2]  = r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);       // add x3, x1, x2
    prog[3]  = r_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);       // sub x4, x3, x1
    prog[4]  = r_word(7'h00, 5'd1, 5'd4, 3'b111, 5'd5);       // and x5, x4, x1
    prog[5]  = r_word(7'h00, 5'd3, 5'd5, 3'b110, 5'd6);       // or x6, x5, x3
    prog[6]  = r_word(7'h00, 5'd4, 5'd6, 3'b100, 5'd7);       // xor x7, x6, x4
    prog[7]  = r_word(7'h00, 5'd1, 5'd4, 3'b010, 5'd8);       // slt x8, x4, x1
    prog[8]  = r_word(7'h00, 5'd4, 5'd1, 3'b010, 5'd9);       // slt x9, x1, x4
    prog[9]  = u_word(20'h12345, 5'd10);                      // lui x10, 0x12345
    prog[10] = i_word(12'h678, 5'd10, 3'b000, 5'd10, op_imm); // addi x10, x10, 0x678
    prog[11] = s_word(12'd16, 5'd10, 5'd0);                   // sw x10, 16(x0)
    prog[12] = i_word(12'd16, 5'd0, 3'b010, 5'd11, op_load);  // lw x11, 16(x0)
    prog[13] = r_word(7'h00, 5'd1, 5'd11, 3'b000, 5'd12);     // add x12, x11, x1
    prog[14] = b_word(13'd12, 5'd1, 5'd1, 3'b000);            // beq x1, x1, +12
    prog[15] = i_word(12'd99, 5'd0, 3'b000, 5'd13, op_imm);   // skipped
    prog[16] = i_word(12'd98, 5'd0, 3'b000, 5'd13, op_imm);   // skipped
    prog[17] = b_word(13'd8, 5'd2, 5'd1, 3'b001);             // bne x1, x2, +8
    prog[18] = i_word(12'd77, 5'd0, 3'b000, 5'd14, op_imm);   // skipped
    prog[19] = b_word(13'd8, 5'd2, 5'd1, 3'b000);             // beq x1, x2 not taken
    prog[20] = i_word(12'd1, 5'd0, 3'b000, 5'd15, op_imm);    // addi x15, x0, 1
    prog[21] = j_word(21'd12, 5'd16);                         // jal x16, +12
    prog[22] = i_word(12'd55, 5'd0, 3'b000, 5'd13, op_imm);   // skipped
    prog[23] = i_word(12'd56, 5'd0, 3'b000, 5'd13, op_imm);   // skipped
    prog[24] = i_word(12'd109, 5'd0, 3'b000, 5'd18, op_imm);  // odd jalr base
    prog[25] = i_word(12'd0, 5'd18, 3'b000, 5'd19, op_jalr);  // jalr x19, 0(x18)
    prog[26] = i_word(12'd57, 5'd0, 3'b000, 5'd13, op_imm);   // skipped
    prog[27] = i_word(12'd123, 5'd0, 3'b000, 5'd0, op_imm);   // addi x0, x0, 123
    prog[28] = r_word(7'h00, 5'd1, 5'd1, 3'b000, 5'd0);       // add x0, x1, x1
    prog[29] = r_word(7'h00, 5'd15, 5'd0, 3'b000, 5'd21);     // add x21, x0, x15
    prog[30] = i_word(12'd3, 5'd0, 3'b000, 5'd17, op_imm);    // a7 = 3
    prog[31] = 32'h0000_0073;                                 // ecall with a7 == 3 is a no-op
    prog[32] = j_word(21'd4, 5'd22);                          // jal x22, +4 links the even pc
    prog[33] = i_word(12'd10, 5'd0, 3'b000, 5'd17, op_imm);   // a7 = 10
    prog[34] = 32'h0000_0073;                                 // halting ecall
    prog[35] = i_word(12'd1, 5'd0, 3'b000, 5'd23, op_imm);    // must not retire
    prog[36] = i_word(12'd2, 5'd0, 3'b000, 5'd24, op_imm);    // must not retire
  endtask

  task automatic stop_failed();
    $display("Done: errors found");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_failed();
    end
  endtask

  initial begin
    void'($urandom(32'h30ec51d2));
    clk       = 1'b0;
    reset     = 1'b1;
    boot_we   = 1'b0;
    boot_addr = '0;
    boot_data = '0;
    build_program();

    // boot load covers all of imem so fetch never sees unwritten words
    for (int k = 0; k < 256; k++) begin
      @(posedge clk);
      #1;
      boot_we   = 1'b1;
      boot_addr = k;
      boot_data = (k < prog_len) ? prog[k] : $urandom;  // garbage above the halt
    end
    @(posedge clk);
    #1;
    boot_we = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    cycles      = 0;
    seen        = 0;
    halt_cycles = 0;
    while (cycles < max_cycles && halt_cycles < drain) begin
      @(negedge clk);  // outputs settled mid-cycle
      cycles++;
      if (is_halted) halt_cycles++;
      if (retire_valid) begin
        if (seen >= n_exp) begin
          $display("unexpected writeback of x%0d at %0t ns, all expected rows already seen",
                   retire_rd, $time);
          stop_failed();
        end else begin
          check_value("retire_rd", {27'd0, retire_rd}, exp_rd[seen]);
          check_value("retire_data", retire_data, exp_data[seen]);
          seen++;
        end
      end
    end

    if (halt_cycles < drain) begin
      $display("timeout: core did not halt within %0d cycles", max_cycles);
      stop_failed();
    end else if (seen != n_exp) begin
      $display("core halted after only %0d of %0d expected writebacks", seen, n_exp);
      stop_failed();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule
